// ==== verilog.f ====
+incdir+rtl
rtl/ahb_arb_pkg.sv
rtl/lru_prior_table.sv
rtl/burst_tracker.sv
rtl/grant_ctrl.sv
rtl/ahb_slave_arbiter.sv
tests/tb_ahb_slave_arbiter.sv

// ==== run.sh ====
#!/bin/sh
# Build the arbiter testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module tb_ahb_slave_arbiter \
  --Mdir obj_dir -o tb_sim \
  && ./obj_dir/tb_sim | tee /dev/stderr | grep -q -F '** PASS **' \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== tests/tb_ahb_slave_arbiter.sv ====
`timescale 1ns/1ps
`include "ahb_arb_defs.svh"

module tb_ahb_slave_arbiter
  import ahb_arb_pkg::*;
;

  logic        hclk;
  logic        hreset_n;
  master_vec_t hreq;
  hburst_e     hburst;
  logic        hwait;
  master_vec_t hgrant;
  logic        hsel;
  logic        hlast;

  // Reference age rank of each master
  rank_t       rank_model [`AHB_MASTER_NUM];
  logic [31:0] lfsr = 32'hed57;
  int          mismatch_count = 0;
  int          timeout_count = 0;

  ahb_slave_arbiter dut_i (
    .hclk     (hclk),
    .hreset_n (hreset_n),
    .hreq     (hreq),
    .hburst   (hburst),
    .hwait    (hwait),
    .hgrant   (hgrant),
    .hsel     (hsel),
    .hlast    (hlast)
  );

  initial
  begin
    hclk = 1'b0;
    forever #10 hclk = ~hclk;
  end

  // ==========================================================================
  // Reference model and helpers
  // ==========================================================================

  // Galois LFSR with taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h80200003;
    else
      return s >> 1;
  endfunction

  function automatic int burst_len(input hburst_e kind);
    case (kind)
      WRAP4, INCR4:   return 4;
      WRAP8, INCR8:   return 8;
      WRAP16, INCR16: return 16;
      default:        return 1;
    endcase
  endfunction

  // Oldest requester wins
  function automatic master_vec_t predict_winner(input master_vec_t req);
    master_vec_t w;
    int          best;
    w    = '0;
    best = -1;
    for (int i = 0; i < `AHB_MASTER_NUM; i++)
    begin
      if (req[i] && (int'(rank_model[i]) > best))
      begin
        w    = '0;
        w[i] = 1'b1;
        best = int'(rank_model[i]);
      end
    end
    return w;
  endfunction

  task automatic age_ranks(input master_vec_t owner);
    rank_t old_rank;
    old_rank = '0;
    for (int i = 0; i < `AHB_MASTER_NUM; i++)
    begin
      if (owner[i])
        old_rank = rank_model[i];
    end
    for (int i = 0; i < `AHB_MASTER_NUM; i++)
    begin
      if (owner[i])
        rank_model[i] = '0;
      else if (rank_model[i] < old_rank)
        rank_model[i] = rank_model[i] + 1'b1;
    end
  endtask

  task automatic compare_vec(input string name, input master_vec_t exp,
                             input master_vec_t act);
    if (act !== exp)
    begin
      mismatch_count++;
      $display("mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      mismatch_count++;
      $display("mismatch at %0t: %s expected %b got %b", $time, name, exp, act);
    end
  endtask

  task automatic apply_reset();
    @(posedge hclk);
    hreset_n <= 1'b0;
    hreq     <= '0;
    hburst   <= SINGLE;
    hwait    <= 1'b0;
    repeat (4) @(posedge hclk);
    hreset_n <= 1'b1;
    for (int i = 0; i < `AHB_MASTER_NUM; i++)
      rank_model[i] = rank_t'(i);
    @(negedge hclk);
  endtask

  task automatic wait_for_grant();
    int n;
    n = 0;
    while ((hsel !== 1'b1) && (n < 50))
    begin
      @(negedge hclk);
      n++;
    end
    if (hsel !== 1'b1)
    begin
      timeout_count++;
      $display("timeout at %0t: no master was granted within 50 cycles", $time);
    end
  endtask

  // One whole burst from first beat to the bubble
  // Owner collects the masters the DUT granted on accepted beats
  task automatic run_burst(input hburst_e kind, input logic rnd_wait,
                           input master_vec_t req_mid, output master_vec_t owner);
    master_vec_t pred;
    master_vec_t exp_grant;
    int          len;
    int          beats;
    int          cycles;
    wait_for_grant();
    pred   = predict_winner(hreq);
    owner  = '0;
    len    = burst_len(kind);
    beats  = 0;
    cycles = 0;
    while ((beats < len) && (cycles < 100))
    begin
      exp_grant = hwait ? master_vec_t'(0) : pred;
      compare_bit("hsel", 1'b1, hsel);
      compare_vec("hgrant", exp_grant, hgrant);
      compare_bit("hlast", logic'(beats == len - 1), hlast);
      if (!hwait)
      begin
        owner = owner | hgrant;
        beats++;
      end
      cycles++;
      @(posedge hclk);
      hreq <= req_mid;
      if (rnd_wait && (beats < len))
      begin
        lfsr = lfsr_step(lfsr);
        hwait <= lfsr[0];
      end
      else
        hwait <= 1'b0;
      @(negedge hclk);
    end
    if (beats < len)
    begin
      timeout_count++;
      $display("timeout at %0t: burst did not finish within 100 cycles", $time);
    end
    compare_bit("hsel in bubble", 1'b0, hsel);
    compare_vec("hgrant in bubble", '0, hgrant);
    compare_bit("hlast in bubble", 1'b0, hlast);
    age_ranks(pred);
  endtask

  // ==========================================================================
  // Directed tests
  // ==========================================================================

  task automatic check_reset_and_first_grant();
    master_vec_t owner;
    compare_bit("hsel after reset", 1'b0, hsel);
    compare_vec("hgrant after reset", '0, hgrant);
    compare_bit("hlast after reset", 1'b0, hlast);
    @(posedge hclk);
    hreq   <= 4'b0100;
    hburst <= SINGLE;
    @(negedge hclk);
    compare_bit("hsel one edge after request", 1'b0, hsel);
    @(posedge hclk);
    @(negedge hclk);
    compare_bit("hsel two edges after request", 1'b1, hsel);
    compare_vec("hgrant two edges after request", 4'b0100, hgrant);
    run_burst(SINGLE, 1'b0, 4'b0000, owner);
    @(negedge hclk);
    compare_bit("hsel back in idle", 1'b0, hsel);
  endtask

  // Every burst type back to back from master 1
  task automatic check_burst_lengths();
    master_vec_t owner;
    logic        last;
    @(posedge hclk);
    hreq   <= 4'b0010;
    hburst <= SINGLE;
    @(negedge hclk);
    for (int k = 0; k < 8; k++)
    begin
      last = (k == 7);
      run_burst(hburst_e'(k), 1'b0, last ? 4'b0000 : 4'b0010, owner);
      @(posedge hclk);
      if (!last)
        hburst <= hburst_e'(k + 1);
      @(negedge hclk);
      compare_bit("hsel after one bubble cycle", !last, hsel);
    end
  endtask

  task automatic check_lru_order();
    master_vec_t owner;
    master_vec_t seen;
    apply_reset();
    @(posedge hclk);
    hreq   <= 4'b1111;
    hburst <= SINGLE;
    @(negedge hclk);
    seen = '0;
    for (int n = 0; n < 8; n++)
    begin
      run_burst(SINGLE, 1'b0, (n == 7) ? 4'b0000 : 4'b1111, owner);
      if (n == 0)
        compare_vec("first owner after reset", 4'b1000, owner);
      seen = seen | owner;
      if ((n % 4) == 3)
      begin
        compare_vec("masters served in four grants", 4'b1111, seen);
        seen = '0;
      end
    end
    @(negedge hclk);
    compare_bit("hsel idle after order test", 1'b0, hsel);
  endtask

  // Master 3 raises its request in the middle of the burst
  task automatic check_back_pressure();
    master_vec_t owner;
    @(posedge hclk);
    hreq   <= 4'b0001;
    hburst <= INCR8;
    @(negedge hclk);
    run_burst(INCR8, 1'b1, 4'b1001, owner);
    compare_vec("owner of stalled INCR8", 4'b0001, owner);
  endtask

  task automatic check_changing_requests();
    master_vec_t owner;
    @(posedge hclk);
    hburst <= INCR4;
    @(negedge hclk);
    run_burst(INCR4, 1'b0, 4'b0110, owner);
    compare_vec("owner after master 0 served", 4'b1000, owner);
    @(posedge hclk);
    hburst <= SINGLE;
    @(negedge hclk);
    run_burst(SINGLE, 1'b0, 4'b0000, owner);
    compare_bit("dropped master 0 granted", 1'b0, owner[0]);
    repeat (3)
    begin
      @(negedge hclk);
      compare_bit("hsel with no requests", 1'b0, hsel);
      compare_vec("hgrant with no requests", '0, hgrant);
    end
  endtask

  // ==========================================================================
  // Main sequence
  // ==========================================================================

  initial
  begin
    hreset_n = 1'b0;
    hreq     = '0;
    hburst   = SINGLE;
    hwait    = 1'b0;
    apply_reset();
    check_reset_and_first_grant();
    check_burst_lengths();
    check_lru_order();
    check_back_pressure();
    check_changing_requests();
    $display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
    if ((mismatch_count == 0) && (timeout_count == 0))
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

// ==== rtl/ahb_slave_arbiter.sv ====
`timescale 1ns/1ps

module ahb_slave_arbiter
  import ahb_arb_pkg::*;
(
  input  logic        hclk,
  input  logic        hreset_n,
  input  master_vec_t hreq,
  input  hburst_e     hburst,
  input  logic        hwait,
  output master_vec_t hgrant,
  output logic        hsel,
  output logic        hlast
);

  master_vec_t grant;
  master_vec_t winner;
  logic        burst_done;

  // ==========================================================================
  // Priority side
  // ==========================================================================

  lru_prior_table prior_i (
    .hclk       (hclk),
    .hreset_n   (hreset_n),
    .hreq       (hreq),
    .grant      (grant),
    .burst_done (burst_done),
    .winner     (winner)
  );

  // ==========================================================================
  // Burst side
  // ==========================================================================

  burst_tracker burst_i (
    .hclk       (hclk),
    .hreset_n   (hreset_n),
    .hsel       (hsel),
    .hwait      (hwait),
    .hburst     (hburst),
    .hlast      (hlast),
    .burst_done (burst_done)
  );

  // Combines winner and burst end into the held grant
  grant_ctrl grant_i (
    .hclk       (hclk),
    .hreset_n   (hreset_n),
    .winner     (winner),
    .burst_done (burst_done),
    .hwait      (hwait),
    .grant      (grant),
    .hsel       (hsel),
    .hgrant     (hgrant)
  );

endmodule

// ==== rtl/grant_ctrl.sv ====
`timescale 1ns/1ps

module grant_ctrl
  import ahb_arb_pkg::*;
(
  input  logic        hclk,
  input  logic        hreset_n,
  input  master_vec_t winner,
  input  logic        burst_done,
  input  logic        hwait,
  output master_vec_t grant,
  output logic        hsel,
  output master_vec_t hgrant
);

  grant_state_e state_q;
  grant_state_e state_d;
  master_vec_t  grant_d;

  // ==========================================================================
  // Grant FSM
  // ==========================================================================

  always_comb
  begin
    state_d = state_q;
    grant_d = grant;
    case (state_q)
      IDLE:
      begin
        if (|winner)
        begin
          grant_d = winner;
          state_d = OWNED;
        end
      end
      OWNED:
      begin
        // Hold until the last beat is taken
        if (burst_done)
        begin
          grant_d = '0;
          state_d = BUBBLE;
        end
      end
      BUBBLE:
      begin
        // Table has aged, pick again
        grant_d = winner;
        state_d = (|winner) ? OWNED : IDLE;
      end
      default:
      begin
        grant_d = '0;
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge hclk or negedge hreset_n)
  begin
    if (!hreset_n)
    begin
      state_q <= IDLE;
      grant   <= '0;
    end
    else
    begin
      state_q <= state_d;
      grant   <= grant_d;
    end
  end

  // Slave side outputs
  assign hsel   = |grant;
  assign hgrant = grant & {$bits(master_vec_t){~hwait}};

  grant_onehot_a: assert property (
    @(posedge hclk) disable iff (!hreset_n) $onehot0(grant))
    else $error("grant_ctrl: more than one master granted");

endmodule

// ==== rtl/burst_tracker.sv ====
`timescale 1ns/1ps

module burst_tracker
  import ahb_arb_pkg::*;
(
  input  logic    hclk,
  input  logic    hreset_n,
  input  logic    hsel,
  input  logic    hwait,
  input  hburst_e hburst,
  output logic    hlast,
  output logic    burst_done
);

  logic      counting_q;
  hburst_e   burst_q;
  hburst_e   burst_cur;
  beat_cnt_t beat_q;
  beat_cnt_t beat_last_idx;
  logic      beat_accept;

  // ==========================================================================
  // Burst length
  // ==========================================================================

  // Live type on the first beat, captured type for the rest
  assign burst_cur = counting_q ? burst_q : hburst;

  // INCR of unknown length is handled as one beat
  always_comb
  begin
    case (burst_cur)
      WRAP4, INCR4:   beat_last_idx = beat_cnt_t'(3);
      WRAP8, INCR8:   beat_last_idx = beat_cnt_t'(7);
      WRAP16, INCR16: beat_last_idx = beat_cnt_t'(15);
      default:        beat_last_idx = '0;
    endcase
  end

  // ==========================================================================
  // Beat counting
  // ==========================================================================

  assign beat_accept = hsel & ~hwait;
  assign hlast       = hsel & (beat_q == beat_last_idx);
  assign burst_done  = beat_accept & hlast;

  always_ff @(posedge hclk or negedge hreset_n)
  begin
    if (!hreset_n)
    begin
      counting_q <= 1'b0;
      beat_q     <= '0;
    end
    else if (beat_accept)
    begin
      if (burst_done)
      begin
        counting_q <= 1'b0;
        beat_q     <= '0;
      end
      else
      begin
        counting_q <= 1'b1;
        beat_q     <= beat_q + 1'b1;
      end
    end
  end

  // Type captured on the first accepted beat
  always_ff @(posedge hclk)
  begin
    if (beat_accept && !counting_q)
      burst_q <= hburst;
  end

  // Every burst end is followed by the bubble
  done_then_bubble_a: assert property (
    @(posedge hclk) disable iff (!hreset_n)
    burst_done |=> !hsel)
    else $error("burst_tracker: no bubble after the last beat");

endmodule

// ==== rtl/lru_prior_table.sv ====
`timescale 1ns/1ps
`include "ahb_arb_defs.svh"

module lru_prior_table
  import ahb_arb_pkg::*;
(
  input  logic        hclk,
  input  logic        hreset_n,
  input  master_vec_t hreq,
  input  master_vec_t grant,
  input  logic        burst_done,
  output master_vec_t winner
);

  rank_t rank_q [`AHB_MASTER_NUM];
  rank_t rank_d [`AHB_MASTER_NUM];
  rank_t served_rank;
  rank_t best_rank;
  logic  found;
  logic  ranks_unique;

  // ==========================================================================
  // Winner selection
  // ==========================================================================

  // Highest rank among requesters
  always_comb
  begin
    winner    = '0;
    best_rank = '0;
    found     = 1'b0;
    for (int i = 0; i < `AHB_MASTER_NUM; i++)
    begin
      if (hreq[i] && (!found || (rank_q[i] > best_rank)))
      begin
        winner    = '0;
        winner[i] = 1'b1;
        best_rank = rank_q[i];
        found     = 1'b1;
      end
    end
  end

  // ==========================================================================
  // Rank aging
  // ==========================================================================

  // Rank of the master that owns the slave now
  always_comb
  begin
    served_rank = '0;
    for (int i = 0; i < `AHB_MASTER_NUM; i++)
    begin
      if (grant[i])
        served_rank = rank_q[i];
    end
  end

  // Served master drops to 0, everyone younger than it ages by one
  always_comb
  begin
    for (int i = 0; i < `AHB_MASTER_NUM; i++)
    begin
      if (grant[i])
        rank_d[i] = '0;
      else if (rank_q[i] < served_rank)
        rank_d[i] = rank_q[i] + 1'b1;
      else
        rank_d[i] = rank_q[i];
    end
  end

  always_ff @(posedge hclk or negedge hreset_n)
  begin
    if (!hreset_n)
    begin
      for (int i = 0; i < `AHB_MASTER_NUM; i++)
        rank_q[i] <= rank_t'(i);
    end
    else if (burst_done)
    begin
      rank_q <= rank_d;
    end
  end

  // Pairwise check of the rank table
  always_comb
  begin
    ranks_unique = 1'b1;
    for (int i = 0; i < `AHB_MASTER_NUM; i++)
    begin
      for (int j = i + 1; j < `AHB_MASTER_NUM; j++)
      begin
        if (rank_q[i] == rank_q[j])
          ranks_unique = 1'b0;
      end
    end
  end

  rank_permutation_a: assert property (
    @(posedge hclk) disable iff (!hreset_n) ranks_unique)
    else $error("lru_prior_table: two masters share a rank");

endmodule

// ==== rtl/ahb_arb_pkg.sv ====
`include "ahb_arb_defs.svh"

package ahb_arb_pkg;

  // One bit per master
  typedef logic [`AHB_MASTER_NUM-1:0] master_vec_t;

  // Age rank where higher means longer since last served
  typedef logic [`AHB_RANK_W-1:0] rank_t;

  // Beat count and last beat index
  typedef logic [`AHB_BEAT_W-1:0] beat_cnt_t;

  // AHB burst encoding
  typedef enum logic [2:0] {
    SINGLE = 3'd0,
    INCR   = 3'd1,
    WRAP4  = 3'd2,
    INCR4  = 3'd3,
    WRAP8  = 3'd4,
    INCR8  = 3'd5,
    WRAP16 = 3'd6,
    INCR16 = 3'd7
  } hburst_e;

  // Grant controller states
  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    OWNED  = 2'd1,
    BUBBLE = 2'd2
  } grant_state_e;

endpackage

// ==== rtl/ahb_arb_defs.svh ====
`ifndef AHB_ARB_DEFS_SVH
`define AHB_ARB_DEFS_SVH

// ==========================================================================
// Arbiter sizing
// ==========================================================================

// Masters sharing the one slave
`define AHB_MASTER_NUM 4

// Rank width for AHB_MASTER_NUM distinct ranks
`define AHB_RANK_W 2

// Beat counter width
// 16 beats is the longest defined burst
`define AHB_BEAT_W 4

// ==========================================================================
// End of sizing
// ==========================================================================

`endif
